// File: bus_sync.sv
`timescale 1ns/1ps

module bus_sync import msu_bus_pkg::*; (
  input  logic       clkin,
  input  logic       reset,
  input  logic       enable,
  input  logic [2:0] reg_addr,
  input  logic       reg_oe,
  input  logic       reg_we,
  input  logic       status_reset_we,
  input  logic       msu_address_ext_write,
  output logic       rd_start,
  output logic       rd_end,
  output logic       wr_pulse,
  output reg_index_e addr_sync,
  output logic       status_update,
  output logic       ptr_load
);

  // First flop of every synchronizer
  logic [4:0] meta;
  // Histories, oldest sample in the top bit
  logic [4:0] oe_hist;
  logic [4:0] we_hist;
  logic [3:0] en_hist;
  logic [1:0] sr_hist;
  logic [1:0] pl_hist;
  reg_index_e addr_meta;
  reg_index_e addr_pipe [4];
  logic       host_ok;

  always_ff @(posedge clkin) begin
    if (reset) begin
      meta    <= '0;
      oe_hist <= '0;
      we_hist <= '0;
      en_hist <= '0;
      sr_hist <= '0;
      pl_hist <= '0;
    end else begin
      meta    <= {msu_address_ext_write, status_reset_we, enable, reg_we, reg_oe};
      oe_hist <= {oe_hist[3:0], meta[0]};
      we_hist <= {we_hist[3:0], meta[1]};
      en_hist <= {en_hist[2:0], meta[2]};
      sr_hist <= {sr_hist[0], meta[3]};
      pl_hist <= {pl_hist[0], meta[4]};
    end
  end

  // Address follows the strobe history stage for stage
  always_ff @(posedge clkin) begin
    addr_meta    <= reg_index_e'(reg_addr);
    addr_pipe[0] <= addr_meta;
    for (int i = 1; i < 4; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
    addr_sync    <= addr_pipe[3];
  end

  // Enable as it was when the first new strobe sample was taken
  assign host_ok = en_hist[3];

  always_ff @(posedge clkin) begin
    if (reset) begin
      rd_start      <= 1'b0;
      rd_end        <= 1'b0;
      wr_pulse      <= 1'b0;
      status_update <= 1'b0;
      ptr_load      <= 1'b0;
    end else begin
      // Old level once, new level four times in a row
      rd_start      <= host_ok && (oe_hist == 5'b01111);
      rd_end        <= host_ok && (oe_hist == 5'b10000);
      wr_pulse      <= host_ok && (we_hist == 5'b01111);
      status_update <= (sr_hist == 2'b01);
      ptr_load      <= (pl_hist == 2'b01);
    end
  end

  // Host cannot read and write in one access
  assert property (@(posedge clkin) disable iff (reset) !(rd_start && wr_pulse))
    else $error("bus_sync: read start and write pulse together");

endmodule

// File: msu_bus_pkg.sv
package msu_bus_pkg;

  // Host register index as decoded on reads
  typedef enum logic [2:0] {
    STATUS = 3'd0,
    DATA   = 3'd1,
    ID0    = 3'd2,
    ID1    = 3'd3,
    ID2    = 3'd4,
    ID3    = 3'd5,
    ID4    = 3'd6,
    ID5    = 3'd7
  } reg_index_e;

  // Same indices as decoded on writes
  localparam reg_index_e SEEK0    = reg_index_e'(3'd0);
  localparam reg_index_e SEEK1    = reg_index_e'(3'd1);
  localparam reg_index_e SEEK2    = reg_index_e'(3'd2);
  localparam reg_index_e SEEK3    = reg_index_e'(3'd3);
  localparam reg_index_e TRACK_LO = reg_index_e'(3'd4);
  localparam reg_index_e TRACK_HI = reg_index_e'(3'd5);
  localparam reg_index_e VOLUME   = reg_index_e'(3'd6);
  localparam reg_index_e CONTROL  = reg_index_e'(3'd7);

  // Status byte returned at register 0
  typedef struct packed {
    logic       data_busy;
    logic       audio_busy;
    logic       audio_repeat;
    logic       audio_playing;
    logic       cmd_overrun;
    logic [2:0] revision;
  } msu_status_s;

endpackage

// File: msu_cmd_queue.sv
`timescale 1ns/1ps
`include "msu_params.svh"

module msu_cmd_queue #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clkin,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  output logic     full,
  output logic     cmd_valid,
  output payload_t cmd_payload,
  input  logic     cmd_credit
);

  localparam int DEPTH      = `MSU_CMD_DEPTH;
  localparam int CREDIT_MAX = `MSU_CREDIT_INIT;
  localparam int PTR_W      = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W      = $clog2(DEPTH + 1);
  localparam int CRD_W      = $clog2(CREDIT_MAX + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CRD_W-1:0] credits;
  logic             accept;
  logic             pop;

  assign full   = (count == CNT_W'(DEPTH));
  assign accept = push && !full;
  // Hand over the oldest entry whenever a credit covers it
  assign pop    = (count != '0) && (credits != '0);

  always_ff @(posedge clkin) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      credits   <= CRD_W'(CREDIT_MAX);
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= pop;
      if (accept) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({accept, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      // Saturate at the initial grant
      case ({cmd_credit, pop})
        2'b10: begin
          if (credits != CRD_W'(CREDIT_MAX)) begin
            credits <= credits + 1'b1;
          end
        end
        2'b01:   credits <= credits - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clkin) begin
    if (accept) begin
      mem[wr_ptr] <= push_data;
    end
    if (pop) begin
      cmd_payload <= mem[rd_ptr];
    end
  end

  // Credit count never wraps below zero or climbs past the grant
  assert property (@(posedge clkin) disable iff (reset) credits <= CRD_W'(CREDIT_MAX))
    else $error("msu_cmd_queue: credit count out of range");
  // Controller returns only what it was given
  assert property (@(posedge clkin) disable iff (reset)
                   cmd_credit |-> credits != CRD_W'(CREDIT_MAX))
    else $error("msu_cmd_queue: credit returned at maximum");

endmodule

// File: msu_databuf.sv
`timescale 1ns/1ps
`include "msu_params.svh"

module msu_databuf (
  input  logic                   clkin,
  input  logic                   wr_en,
  input  logic [`MSU_ADDR_W-1:0] wr_addr,
  input  logic [7:0]             wr_data,
  input  logic [`MSU_ADDR_W-1:0] rd_addr,
  output logic [7:0]             rd_data
);

  localparam int DEPTH = 2 ** `MSU_ADDR_W;

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  logic [7:0] mem [DEPTH];

  // Loader side
  always_ff @(posedge clkin) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stream side
  ////////////////////////////////////////////////////////////////////////////

  // Registered read, one cycle behind the pointer.
  // A collision with the loader returns the old byte
  always_ff @(posedge clkin) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: msu_params.svh
`ifndef MSU_PARAMS_SVH
`define MSU_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Data buffer
////////////////////////////////////////////////////////////////////////////

// Byte address into the data buffer, 16 KiB deep
`define MSU_ADDR_W 14

////////////////////////////////////////////////////////////////////////////
// Command path to the streaming controller
////////////////////////////////////////////////////////////////////////////

// Entries in each command queue
`define MSU_CMD_DEPTH 4

// Credits each queue starts with
`define MSU_CREDIT_INIT 2

// Interface revision in the low bits of the status byte
`define MSU_REVISION 3'd1

`endif

// File: msu_regs.sv
`timescale 1ns/1ps
`include "msu_params.svh"

module msu_regs import msu_bus_pkg::*, msu_stream_pkg::*; (
  input  logic                   clkin,
  input  logic                   reset,
  input  logic                   rd_start,
  input  logic                   rd_end,
  input  logic                   wr_pulse,
  input  reg_index_e             addr_sync,
  input  logic [7:0]             reg_data_in,
  output logic [7:0]             reg_data_out,
  input  logic                   status_update,
  input  logic [5:0]             status_set_bits,
  input  logic [5:0]             status_reset_bits,
  input  logic                   ptr_load,
  input  logic [`MSU_ADDR_W-1:0] msu_address_ext,
  output logic [`MSU_ADDR_W-1:0] buf_addr,
  input  logic [7:0]             buf_data,
  output logic [31:0]            addr_out,
  output logic [15:0]            track_out,
  output logic [7:0]             volume_out,
  output logic                   volume_latch,
  output logic [6:0]             status_out,
  output logic                   seek_push,
  output seek_cmd_s              seek_cmd,
  input  logic                   seek_full,
  output logic                   track_push,
  output track_cmd_s             track_cmd,
  input  logic                   track_full
);

  logic [`MSU_ADDR_W-1:0] ptr;
  logic                   data_busy;
  logic                   audio_busy;
  logic                   data_start;
  logic                   audio_start;
  logic                   ctrl_start;
  logic [1:0]             audio_ctrl;
  // Bit 1 repeat, bit 0 playing
  logic [1:0]             audio_status;
  logic                   cmd_overrun;
  msu_status_s            status_byte;

  assign buf_addr = ptr;

  assign status_byte = '{
    data_busy:     data_busy,
    audio_busy:    audio_busy,
    audio_repeat:  audio_status[1],
    audio_playing: audio_status[0],
    cmd_overrun:   cmd_overrun,
    revision:      `MSU_REVISION
  };

  assign status_out = {ptr[`MSU_ADDR_W-1], audio_start, data_start, volume_latch,
                       audio_ctrl, ctrl_start};

  ////////////////////////////////////////////////////////////////////////////
  // Host reads
  ////////////////////////////////////////////////////////////////////////////

  // Held until the next read start
  always_ff @(posedge clkin) begin
    if (rd_start) begin
      case (addr_sync)
        STATUS: reg_data_out <= status_byte;
        DATA:   reg_data_out <= buf_data;
        // "S-MSU1"
        ID0:    reg_data_out <= 8'h53;
        ID1:    reg_data_out <= 8'h2d;
        ID2:    reg_data_out <= 8'h4d;
        ID3:    reg_data_out <= 8'h53;
        ID4:    reg_data_out <= 8'h55;
        ID5:    reg_data_out <= 8'h31;
      endcase
    end
  end

  // Stream pointer, controller load beats auto increment
  always_ff @(posedge clkin) begin
    if (reset) begin
      ptr <= '0;
    end else if (ptr_load) begin
      ptr <= msu_address_ext;
    end else if (rd_end && (addr_sync == DATA)) begin
      ptr <= ptr + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Status bits and command requests
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clkin) begin
    if (reset) begin
      data_busy    <= 1'b0;
      audio_busy   <= 1'b0;
      data_start   <= 1'b0;
      audio_start  <= 1'b0;
      ctrl_start   <= 1'b0;
      audio_ctrl   <= '0;
      audio_status <= '0;
      cmd_overrun  <= 1'b0;
      volume_latch <= 1'b0;
      seek_push    <= 1'b0;
      track_push   <= 1'b0;
    end else begin
      volume_latch <= 1'b0;
      seek_push    <= 1'b0;
      track_push   <= 1'b0;
      // Controller update, reset wins over set
      if (status_update) begin
        audio_busy   <= (audio_busy | status_set_bits[5]) & ~status_reset_bits[5];
        data_busy    <= (data_busy | status_set_bits[4]) & ~status_reset_bits[4];
        cmd_overrun  <= (cmd_overrun | status_set_bits[3]) & ~status_reset_bits[3];
        audio_status <= (audio_status | status_set_bits[2:1]) & ~status_reset_bits[2:1];
        ctrl_start   <= (ctrl_start | status_set_bits[0]) & ~status_reset_bits[0];
        if (status_reset_bits[5]) begin
          audio_start <= 1'b0;
        end
        if (status_reset_bits[4]) begin
          data_start <= 1'b0;
        end
      end
      if (wr_pulse) begin
        case (addr_sync)
          SEEK3: begin
            data_busy  <= 1'b1;
            data_start <= 1'b1;
            if (seek_full) begin
              cmd_overrun <= 1'b1;
            end else begin
              seek_push <= 1'b1;
            end
          end
          TRACK_HI: begin
            audio_busy  <= 1'b1;
            audio_start <= 1'b1;
            if (track_full) begin
              cmd_overrun <= 1'b1;
            end else begin
              track_push <= 1'b1;
            end
          end
          VOLUME: volume_latch <= 1'b1;
          // Ignored while a track change is pending
          CONTROL: begin
            if (!audio_busy) begin
              audio_ctrl <= reg_data_in[1:0];
              ctrl_start <= 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Register contents and command payloads
  always_ff @(posedge clkin) begin
    if (wr_pulse) begin
      case (addr_sync)
        SEEK0: addr_out[7:0]   <= reg_data_in;
        SEEK1: addr_out[15:8]  <= reg_data_in;
        SEEK2: addr_out[23:16] <= reg_data_in;
        SEEK3: begin
          addr_out[31:24] <= reg_data_in;
          seek_cmd.offset <= {reg_data_in, addr_out[23:0]};
        end
        TRACK_LO: track_out[7:0] <= reg_data_in;
        TRACK_HI: begin
          track_out[15:8] <= reg_data_in;
          track_cmd.track <= {reg_data_in, track_out[7:0]};
          track_cmd.ctrl  <= audio_ctrl;
        end
        VOLUME: volume_out <= reg_data_in;
        default: ;
      endcase
    end
  end

  // Full queues must turn into overrun, never into a push
  assert property (@(posedge clkin) disable iff (reset) !(seek_push && seek_full))
    else $error("msu_regs: seek push into full queue");
  assert property (@(posedge clkin) disable iff (reset) !(track_push && track_full))
    else $error("msu_regs: track push into full queue");

endmodule

// File: msu_stream_pkg.sv
package msu_stream_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Commands handed to the streaming controller
  ////////////////////////////////////////////////////////////////////////////

  // Seek request
  // Byte offset into the data file, all four seek bytes
  typedef struct packed {
    logic [31:0] offset;
  } seek_cmd_s;

  // Track request
  // The control field is the value in force when the track was requested,
  // so the controller knows whether to start in repeat mode
  typedef struct packed {
    logic [15:0] track;
    logic [1:0]  ctrl;
  } track_cmd_s;

endpackage

// File: msu_tb.sv
`timescale 1ns/1ps
`include "msu_params.svh"

module msu_tb import msu_bus_pkg::*, msu_stream_pkg::*; ();

  localparam int OP_RD       = 0;
  localparam int OP_WR       = 1;
  localparam int OP_CLR      = 2;
  localparam int OP_CK_ADDR  = 3;
  localparam int OP_CK_TRACK = 4;
  localparam int OP_CK_VOL   = 5;
  localparam int OP_SNAP     = 6;
  localparam int OP_SAME     = 7;
  localparam int WAIT_LIMIT  = 200;
  localparam logic [`MSU_ADDR_W-1:0] BUF_BASE = 14'h3ffa;

  logic clkin, reset, enable;
  logic [`MSU_ADDR_W-1:0] pgm_address;
  logic [7:0] pgm_data;
  logic pgm_we;
  logic [2:0] reg_addr;
  logic [7:0] reg_data_in, reg_data_out;
  logic reg_oe, reg_we;
  logic [6:0] status_out;
  logic [7:0] volume_out;
  logic volume_latch;
  logic [31:0] addr_out;
  logic [15:0] track_out;
  logic [5:0] status_reset_bits, status_set_bits;
  logic status_reset_we;
  logic [`MSU_ADDR_W-1:0] msu_address_ext;
  logic msu_address_ext_write;
  logic seek_valid, seek_credit, track_valid, track_credit;
  seek_cmd_s seek_cmd;
  track_cmd_s track_cmd;

  int checks = 0;
  int errors = 0;
  int timeouts = 0;
  int latch_pulses = 0;
  logic [31:0] seek_seen [$];
  logic [15:0] track_seen [$];
  logic [1:0] ctrl_seen [$];
  int step_op [$];
  logic [2:0] step_idx [$];
  logic [7:0] step_data [$];
  logic [31:0] step_exp [$];
  logic [6:0] status_snap;
  logic [7:0] shadow [16];
  logic [31:0] seek_list [7];
  logic [7:0] rd_value;

  msu_top i_msu_top (.*);

  initial begin
    clkin = 1'b0;
    forever #2 clkin = ~clkin;
  end

  // Controller model records every command handed over
  always @(posedge clkin) begin
    if (seek_valid === 1'b1) begin
      seek_seen.push_back(seek_cmd.offset);
    end
    if (track_valid === 1'b1) begin
      track_seen.push_back(track_cmd.track);
      ctrl_seen.push_back(track_cmd.ctrl);
    end
    if (volume_latch === 1'b1) begin
      latch_pulses++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge clkin);
  endtask

  // Status byte as laid out in the register map
  function automatic logic [31:0] status_exp(input logic db, input logic ab,
                                             input logic ovr);
    return {24'h0, db, ab, 2'b00, ovr, `MSU_REVISION};
  endfunction

  // Strobes held 8 cycles with address and data steady through the gap
  task automatic host_read(input logic [2:0] idx, output logic [7:0] value);
    reg_addr = idx;
    reg_oe   = 1'b1;
    idle(8);
    reg_oe = 1'b0;
    idle(8);
    value = reg_data_out;
  endtask

  task automatic host_write(input logic [2:0] idx, input logic [7:0] data);
    reg_addr    = idx;
    reg_data_in = data;
    reg_we      = 1'b1;
    idle(8);
    reg_we = 1'b0;
    idle(8);
  endtask

  task automatic status_write(input logic [5:0] set_bits, input logic [5:0] reset_bits);
    status_set_bits   = set_bits;
    status_reset_bits = reset_bits;
    idle(1);
    status_reset_we = 1'b1;
    idle(8);
    status_reset_we = 1'b0;
    idle(8);
    status_set_bits   = '0;
    status_reset_bits = '0;
  endtask

  task automatic pointer_load(input logic [`MSU_ADDR_W-1:0] addr);
    msu_address_ext = addr;
    idle(1);
    msu_address_ext_write = 1'b1;
    idle(8);
    msu_address_ext_write = 1'b0;
    idle(8);
  endtask

  task automatic seek_request(input logic [31:0] offset);
    host_write(SEEK0, offset[7:0]);
    host_write(SEEK1, offset[15:8]);
    host_write(SEEK2, offset[23:16]);
    host_write(SEEK3, offset[31:24]);
  endtask

  task automatic return_credit(input logic to_track);
    if (to_track) begin
      track_credit = 1'b1;
    end else begin
      seek_credit = 1'b1;
    end
    idle(1);
    seek_credit  = 1'b0;
    track_credit = 1'b0;
    idle(2);
  endtask

  task automatic wait_commands(input logic on_track, input int target, input string what);
    int n;
    n = 0;
    while (((on_track ? track_seen.size() : seek_seen.size()) < target) && n < WAIT_LIMIT) begin
      @(negedge clkin);
      n++;
    end
    if ((on_track ? track_seen.size() : seek_seen.size()) < target) begin
      timeouts++;
      $display("Timeout while waiting for %s", what);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_step(input int op, input logic [2:0] idx, input logic [7:0] data,
                          input logic [31:0] exp);
    step_op.push_back(op);
    step_idx.push_back(idx);
    step_data.push_back(data);
    step_exp.push_back(exp);
  endtask

  task automatic build_table();
    string id_text;
    id_text = "S-MSU1";
    // Identity and status after reset
    for (int k = 0; k < 6; k++) begin
      add_step(OP_RD, 3'(k + 2), 8'h00, {24'h0, id_text[k]});
    end
    add_step(OP_RD, STATUS, 8'h00, status_exp(0, 0, 0));
    // Seek, then controller clears data busy
    add_step(OP_WR, SEEK0, 8'h78, 0);
    add_step(OP_WR, SEEK1, 8'h56, 0);
    add_step(OP_WR, SEEK2, 8'h34, 0);
    add_step(OP_WR, SEEK3, 8'h12, 0);
    add_step(OP_CK_ADDR, 0, 8'h00, 32'h1234_5678);
    add_step(OP_RD, STATUS, 8'h00, status_exp(1, 0, 0));
    add_step(OP_CLR, 0, 8'h10, 0);
    add_step(OP_RD, STATUS, 8'h00, status_exp(0, 0, 0));
    // Track request with control locked out while busy
    add_step(OP_WR, TRACK_LO, 8'h34, 0);
    add_step(OP_WR, TRACK_HI, 8'h12, 0);
    add_step(OP_CK_TRACK, 0, 8'h00, 32'h1234);
    add_step(OP_RD, STATUS, 8'h00, status_exp(0, 1, 0));
    add_step(OP_SNAP, 0, 8'h00, 0);
    add_step(OP_WR, CONTROL, 8'h03, 0);
    add_step(OP_SAME, 0, 8'h00, 0);
    add_step(OP_CLR, 0, 8'h20, 0);
    add_step(OP_RD, STATUS, 8'h00, status_exp(0, 0, 0));
    add_step(OP_WR, CONTROL, 8'h03, 0);
    add_step(OP_WR, TRACK_LO, 8'h78, 0);
    add_step(OP_WR, TRACK_HI, 8'h56, 0);
    add_step(OP_CK_TRACK, 0, 8'h00, 32'h5678);
    add_step(OP_RD, STATUS, 8'h00, status_exp(0, 1, 0));
    add_step(OP_CLR, 0, 8'h20, 0);
    add_step(OP_RD, STATUS, 8'h00, status_exp(0, 0, 0));
    // Volume
    add_step(OP_WR, VOLUME, 8'ha5, 0);
    add_step(OP_CK_VOL, 0, 8'h00, 32'ha5);
  endtask

  task automatic run_table();
    logic [7:0] got;
    for (int s = 0; s < step_op.size(); s++) begin
      case (step_op[s])
        OP_RD: begin
          host_read(step_idx[s], got);
          check_value($sformatf("reg_data_out (reg %0d)", step_idx[s]), got, step_exp[s]);
        end
        OP_WR:       host_write(step_idx[s], step_data[s]);
        OP_CLR:      status_write(6'h00, step_data[s][5:0]);
        OP_CK_ADDR:  check_value("addr_out", addr_out, step_exp[s]);
        OP_CK_TRACK: check_value("track_out", track_out, step_exp[s]);
        OP_CK_VOL:   check_value("volume_out", volume_out, step_exp[s]);
        OP_SNAP:     status_snap = status_out;
        OP_SAME:     check_value("status_out", status_out, status_snap);
        default:     ;
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hfd513a6a));
    reset = 1'b1;
    enable = 1'b1;
    pgm_address = '0;
    pgm_data = '0;
    pgm_we = 1'b1;
    reg_addr = '0;
    reg_data_in = '0;
    reg_oe = 1'b0;
    reg_we = 1'b0;
    status_reset_bits = '0;
    status_set_bits = '0;
    status_reset_we = 1'b0;
    msu_address_ext = '0;
    msu_address_ext_write = 1'b0;
    seek_credit = 1'b0;
    track_credit = 1'b0;
    repeat (4) @(negedge clkin);
    reset = 1'b0;
    idle(8);

    build_table();
    run_table();

    // Commands produced by the table
    wait_commands(1'b0, 1, "the seek command");
    wait_commands(1'b1, 2, "both track commands");
    idle(16);
    check_value("seek command count", seek_seen.size(), 1);
    if (seek_seen.size() == 1) begin
      check_value("seek_cmd.offset", seek_seen[0], 32'h1234_5678);
    end
    check_value("track command count", track_seen.size(), 2);
    if (track_seen.size() == 2) begin
      check_value("track_cmd.track", track_seen[0], 16'h1234);
      check_value("track_cmd.ctrl", ctrl_seen[0], 2'd0);
      check_value("track_cmd.track", track_seen[1], 16'h5678);
      check_value("track_cmd.ctrl", ctrl_seen[1], 2'd3);
    end
    check_value("volume_latch pulses", latch_pulses, 1);
    return_credit(1'b0);
    return_credit(1'b1);
    return_credit(1'b1);

    // Buffer fill across the address wrap, then data port reads
    for (int i = 0; i < 16; i++) begin
      shadow[i] = $urandom & 8'hff;
      pgm_address = BUF_BASE + i;
      pgm_data = shadow[i];
      pgm_we = 1'b0;
      @(negedge clkin);
    end
    pgm_we = 1'b1;
    pointer_load(BUF_BASE);
    for (int i = 0; i < 12; i++) begin
      host_read(DATA, rd_value);
      check_value($sformatf("reg_data_out (data byte %0d)", i), rd_value, shadow[i]);
    end

    // Back-pressure on the seek queue
    for (int k = 0; k < 7; k++) begin
      seek_list[k] = 32'h8000_0000 + k * 32'h0102_0304;
    end
    seek_request(seek_list[0]);
    seek_request(seek_list[1]);
    wait_commands(1'b0, 3, "the seeks covered by credits");
    for (int k = 2; k < 6; k++) begin
      seek_request(seek_list[k]);
    end
    check_value("seek command count", seek_seen.size(), 3);
    host_read(STATUS, rd_value);
    check_value("reg_data_out (status)", rd_value, status_exp(1, 0, 0));
    seek_request(seek_list[6]);
    host_read(STATUS, rd_value);
    check_value("reg_data_out (status)", rd_value, status_exp(1, 0, 1));
    for (int k = 0; k < 4; k++) begin
      return_credit(1'b0);
      wait_commands(1'b0, 4 + k, "a seek command after a returned credit");
    end
    idle(16);
    check_value("seek command count", seek_seen.size(), 7);
    if (seek_seen.size() == 7) begin
      for (int k = 0; k < 6; k++) begin
        check_value("seek_cmd.offset", seek_seen[k + 1], seek_list[k]);
      end
    end
    status_write(6'h00, 6'h18);
    host_read(STATUS, rd_value);
    check_value("reg_data_out (status)", rd_value, status_exp(0, 0, 0));

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: msu_top.sv
`timescale 1ns/1ps
`include "msu_params.svh"

module msu_top import msu_bus_pkg::*, msu_stream_pkg::*; (
  input  logic                   clkin,
  input  logic                   reset,
  input  logic                   enable,
  // Loader port
  input  logic [`MSU_ADDR_W-1:0] pgm_address,
  input  logic [7:0]             pgm_data,
  input  logic                   pgm_we,
  // Host bus
  input  logic [2:0]             reg_addr,
  input  logic [7:0]             reg_data_in,
  output logic [7:0]             reg_data_out,
  input  logic                   reg_oe,
  input  logic                   reg_we,
  // Register outputs
  output logic [6:0]             status_out,
  output logic [7:0]             volume_out,
  output logic                   volume_latch,
  output logic [31:0]            addr_out,
  output logic [15:0]            track_out,
  // Controller status and pointer ports
  input  logic [5:0]             status_reset_bits,
  input  logic [5:0]             status_set_bits,
  input  logic                   status_reset_we,
  input  logic [`MSU_ADDR_W-1:0] msu_address_ext,
  input  logic                   msu_address_ext_write,
  // Command queues
  output logic                   seek_valid,
  output seek_cmd_s              seek_cmd,
  input  logic                   seek_credit,
  output logic                   track_valid,
  output track_cmd_s             track_cmd,
  input  logic                   track_credit
);

  logic                   rd_start;
  logic                   rd_end;
  logic                   wr_pulse;
  reg_index_e             addr_sync;
  logic                   status_update;
  logic                   ptr_load;
  logic [`MSU_ADDR_W-1:0] buf_addr;
  logic [7:0]             buf_data;
  logic                   seek_push;
  seek_cmd_s              seek_req;
  logic                   seek_full;
  logic                   track_push;
  track_cmd_s             track_req;
  logic                   track_full;

  bus_sync i_bus_sync (
    .clkin, .reset, .enable, .reg_addr, .reg_oe, .reg_we, .status_reset_we,
    .msu_address_ext_write, .rd_start, .rd_end, .wr_pulse, .addr_sync,
    .status_update, .ptr_load
  );

  msu_regs i_msu_regs (
    .clkin, .reset, .rd_start, .rd_end, .wr_pulse, .addr_sync, .reg_data_in,
    .reg_data_out, .status_update, .status_set_bits, .status_reset_bits,
    .ptr_load, .msu_address_ext, .buf_addr, .buf_data, .addr_out, .track_out,
    .volume_out, .volume_latch, .status_out,
    .seek_push, .seek_cmd(seek_req), .seek_full,
    .track_push, .track_cmd(track_req), .track_full
  );

  // Loader write strobe is active low
  msu_databuf i_msu_databuf (
    .clkin,
    .wr_en   (~pgm_we),
    .wr_addr (pgm_address),
    .wr_data (pgm_data),
    .rd_addr (buf_addr),
    .rd_data (buf_data)
  );

  msu_cmd_queue #(.payload_t(seek_cmd_s)) i_seek_queue (
    .clkin, .reset,
    .push        (seek_push),
    .push_data   (seek_req),
    .full        (seek_full),
    .cmd_valid   (seek_valid),
    .cmd_payload (seek_cmd),
    .cmd_credit  (seek_credit)
  );

  msu_cmd_queue #(.payload_t(track_cmd_s)) i_track_queue (
    .clkin, .reset,
    .push        (track_push),
    .push_data   (track_req),
    .full        (track_full),
    .cmd_valid   (track_valid),
    .cmd_payload (track_cmd),
    .cmd_credit  (track_credit)
  );

endmodule

// File: vlog.f
+incdir+.
msu_bus_pkg.sv
msu_stream_pkg.sv
bus_sync.sv
msu_databuf.sv
msu_regs.sv
msu_cmd_queue.sv
msu_top.sv
msu_tb.sv
